//--- mm_stream_buffer.f
+incdir+hw
hw/mm_buf_pkg.sv
hw/stream_fifo.sv
hw/burst_arbiter.sv
hw/ring_tracker.sv
hw/burst_sizer.sv
hw/mm_stream_buffer.sv
dv/mm_stream_buffer_tb.sv

//--- dv/mm_stream_buffer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mm_stream_buffer_tb;

    import mm_buf_pkg::*;

    localparam int NWORDS    = 4000;    // Input words per run
    localparam int BP_CYCLES = 500;     // Output blocked phase
    localparam int PERIOD    = 4;

    logic   clk;
    logic   reset;
    data_t  i_dat;
    logic   i_val;
    logic   o_rdy_in;
    data_t  o_dat;
    logic   o_val;
    logic   i_rdy_out;
    addr_t  o_m_addr;
    bcnt_t  o_m_bcnt;
    logic   o_m_wreq;
    data_t  o_m_wdat;
    logic   o_m_rreq;
    data_t  i_m_rdat;
    logic   i_m_rval;
    logic   i_m_busy;

    integer seed;
    logic   driving;                    // Random stimulus running
    logic   src_on;                     // Input stream enabled
    logic   bp_phase;                   // Output sink held off
    logic   saw_in_block;               // o_rdy_in low seen while held off

    //------------------------------------------------------------
    // Scoreboard and memory model
    data_t  in_q[$];                    // Accepted input words, oldest first
    data_t  rd_q[$];                    // Read words the memory still owes
    data_t  mem [CAPACITY];
    addr_t  wr_ptr;
    addr_t  rd_ptr;
    bcnt_t  wr_len;                     // Length of the write burst in flight
    int     wr_idx;                     // Beat within that burst
    int     ring_level;                 // Written but not yet read
    int     in_cnt;
    int     err_data, err_addr, err_bcnt, err_flag, err_other;

    mm_stream_buffer mm_stream_buffer_inst (
        .clk(clk), .reset(reset),
        .i_dat(i_dat), .i_val(i_val), .o_rdy_in(o_rdy_in),
        .o_dat(o_dat), .o_val(o_val), .i_rdy_out(i_rdy_out),
        .o_m_addr(o_m_addr), .o_m_bcnt(o_m_bcnt), .o_m_wreq(o_m_wreq),
        .o_m_wdat(o_m_wdat), .o_m_rreq(o_m_rreq), .i_m_rdat(i_m_rdat),
        .i_m_rval(i_m_rval), .i_m_busy(i_m_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //------------------------------------------------------------
    // Compare tasks
    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            err_data++;
            $display("Fail %s: expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            err_addr++;
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Accepts any length from lo to hi inclusive
    task automatic check_bcnt(input string name, input bcnt_t lo, input bcnt_t hi,
                              input bcnt_t act);
        if ($isunknown(act) || act < lo || act > hi) begin
            err_bcnt++;
            $display("Fail %s: expected %0d..%0d actual %0d", name, lo, hi, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_flag++;
            $display("Fail %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: data %0d, address %0d, length %0d, flag %0d, other %0d",
                 err_data, err_addr, err_bcnt, err_flag, err_other);
    endtask

    //------------------------------------------------------------
    // Memory side of the model
    task automatic write_beat();
        if (wr_idx == 0) begin                          // First beat fixes the burst
            check_addr("write burst address", wr_ptr, o_m_addr);
            check_bcnt("write burst length", bcnt_t'(1), bcnt_t'(MAXBURST), o_m_bcnt);
            wr_len = o_m_bcnt;
        end else begin
            check_addr("write address hold", wr_ptr, o_m_addr);
            check_bcnt("write length hold", wr_len, wr_len, o_m_bcnt);
        end
        mem[(int'(wr_ptr) + wr_idx) % CAPACITY] = o_m_wdat;
        ring_level++;
        if (ring_level > int'(CAPACITY)) begin
            err_other++;
            $display("Ring overrun with %0d words written but not read", ring_level);
        end
        wr_idx++;
        if (wr_idx >= int'(wr_len)) begin             // Burst complete
            wr_ptr = addr_t'((int'(wr_ptr) + int'(wr_len)) % CAPACITY);
            wr_idx = 0;
        end
    endtask

    task automatic accept_read();
        int room;
        room = (ring_level < int'(MAXBURST)) ? ring_level : int'(MAXBURST);
        if (room < 0)
            room = 0;
        check_addr("read burst address", rd_ptr, o_m_addr);
        check_bcnt("read burst length", bcnt_t'(1), bcnt_t'(room), o_m_bcnt);
        for (int i = 0; i < int'(o_m_bcnt); i++)
            rd_q.push_back(mem[(int'(rd_ptr) + i) % CAPACITY]);   // Data as of the accept
        rd_ptr = addr_t'((int'(rd_ptr) + int'(o_m_bcnt)) % CAPACITY);
        ring_level -= int'(o_m_bcnt);
    endtask

    task automatic wait_words(input int n);
        while (in_cnt < n)
            @(posedge clk);
    endtask

    //------------------------------------------------------------
    // Drive 1 ns after each rising edge
    always @(posedge clk) begin
        #1;
        if (driving) begin
            i_val     = src_on && (($random(seed) & 3) != 0);
            i_dat     = data_t'($random(seed));
            i_rdy_out = !bp_phase && (($random(seed) & 7) != 0);
            i_m_busy  = (($random(seed) & 3) == 0);        // Memory stalls a quarter of cycles
            if (rd_q.size() != 0 && ($random(seed) & 1)) begin
                i_m_rval = 1'b1;
                i_m_rdat = rd_q.pop_front();
            end else begin
                i_m_rval = 1'b0;
            end
        end
    end

    // Sample mid-cycle where all values are stable
    always @(negedge clk) begin
        if (!reset && driving) begin
            if (i_val && o_rdy_in) begin
                in_q.push_back(i_dat);
                in_cnt++;
            end
            if (bp_phase && !o_rdy_in)
                saw_in_block = 1'b1;
            if (o_val && i_rdy_out) begin
                if (in_q.size() == 0) begin
                    err_other++;
                    $display("Output word %0h appeared with no input word to match", o_dat);
                end else begin
                    check_data("stream order", in_q.pop_front(), o_dat);
                end
            end
            if (o_m_wreq && !i_m_busy)
                write_beat();
            if (o_m_rreq && !i_m_busy)
                accept_read();
        end
    end

    // Watchdog sized from the stream length
    initial begin
        #(NWORDS * 40 * PERIOD);
        $display("Watchdog expired: the stream stalled after %0d input words", in_cnt);
        print_error_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    //------------------------------------------------------------
    // Main sequence
    initial begin
        seed         = 32'haac8595c;
        reset        = 1'b1;
        driving      = 1'b0;
        src_on       = 1'b0;
        bp_phase     = 1'b0;
        saw_in_block = 1'b0;
        i_dat        = '0;
        i_val        = 1'b0;
        i_rdy_out    = 1'b1;
        i_m_rdat     = '0;
        i_m_rval     = 1'b0;
        i_m_busy     = 1'b0;
        wr_ptr       = '0;
        rd_ptr       = '0;
        wr_len       = '0;
        wr_idx       = 0;
        ring_level   = 0;
        in_cnt       = 0;
        err_data     = 0;
        err_addr     = 0;
        err_bcnt     = 0;
        err_flag     = 0;
        err_other    = 0;
        for (int a = 0; a < int'(CAPACITY); a++)
            mem[a] = data_t'(8'h5a ^ (a * 3));          // Distinct word per address

        repeat (2) @(posedge clk);
        driving = 1'b1;                                 // Stimulus starts with the reset release
        src_on  = 1'b1;
        #1;
        reset   = 1'b0;
        @(negedge clk);                                 // Still reset values here
        check_flag("reset write request", 1'b0, o_m_wreq);
        check_flag("reset read request", 1'b0, o_m_rreq);
        check_flag("reset output valid", 1'b0, o_val);
        check_flag("reset input ready", 1'b1, o_rdy_in);

        wait_words(NWORDS / 2);
        bp_phase = 1'b1;                                // Sink blocked so the ring fills up
        repeat (BP_CYCLES) @(posedge clk);
        bp_phase = 1'b0;
        if (!saw_in_block) begin
            err_other++;
            $display("Input ready never dropped while the output was blocked");
        end

        wait_words(NWORDS);
        src_on = 1'b0;
        while (in_q.size() != 0)                        // Drain the whole path
            @(posedge clk);
        repeat (20) @(posedge clk);                     // Stray words would show here
        if (ring_level != 0 || rd_q.size() != 0) begin
            err_other++;
            $display("Ring not drained: %0d words left, %0d reads owed", ring_level, rd_q.size());
        end

        print_error_counts();
        if (err_data + err_addr + err_bcnt + err_flag + err_other == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : mm_stream_buffer_tb

`default_nettype wire

//--- hw/mm_stream_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_buf_cfg.svh"

module mm_stream_buffer (
    input  wire                         clk,
    input  wire                         reset,

    // Input stream
    input  wire mm_buf_pkg::data_t      i_dat,
    input  wire                         i_val,
    output logic                        o_rdy_in,

    // Output stream
    output mm_buf_pkg::data_t           o_dat,
    output logic                        o_val,
    input  wire                         i_rdy_out,

    // Memory master
    output mm_buf_pkg::addr_t           o_m_addr,
    output mm_buf_pkg::bcnt_t           o_m_bcnt,
    output logic                        o_m_wreq,
    output mm_buf_pkg::data_t           o_m_wdat,
    output logic                        o_m_rreq,
    input  wire mm_buf_pkg::data_t      i_m_rdat,
    input  wire                         i_m_rval,
    input  wire                         i_m_busy
);

    import mm_buf_pkg::*;

    ififo_cnt_t ififo_used;
    logic       ififo_empty;
    logic       ififo_full;
    logic       ofifo_empty;
    logic       out_pop;        // Output handshake
    logic       rw_sel;
    logic       wr_beat;
    logic       rd_accept;
    logic       wr_last;
    logic       wr_ready;
    logic       rd_ready;
    logic       rd_stall;
    bcnt_t      rd_bcnt;
    ring_cnt_t  used_cnt;
    ring_cnt_t  free_cnt;
    logic       ring_full;
    logic       ring_empty;

    //------------------------------------------------------------
    // Stream buffers
    stream_fifo #(.T(data_t), .DEPTH(`MMB_IDEPTH)) ififo_inst (
        .clk(clk), .reset(reset),
        .i_data(i_dat), .i_push(i_val), .i_pop(wr_beat),
        .o_data(o_m_wdat), .o_empty(ififo_empty), .o_full(ififo_full), .o_used(ififo_used)
    );

    stream_fifo #(.T(data_t), .DEPTH(`MMB_ODEPTH)) ofifo_inst (
        .clk(clk), .reset(reset),
        .i_data(i_m_rdat), .i_push(i_m_rval), .i_pop(out_pop),
        .o_data(o_dat), .o_empty(ofifo_empty), .o_full(), .o_used()
    );

    assign o_rdy_in = ~ififo_full;
    assign o_val    = ~ofifo_empty;
    assign out_pop  = o_val & i_rdy_out;

    // Burst conditions seen by the arbiter
    assign wr_ready = ~ring_full & ~ififo_empty;
    assign rd_ready = ~ring_empty & ~rd_stall;

    burst_arbiter arbiter_inst (
        .clk(clk), .reset(reset), .i_busy(i_m_busy),
        .i_wr_ready(wr_ready), .i_rd_ready(rd_ready), .i_wr_last(wr_last),
        .o_wr_req(o_m_wreq), .o_rd_req(o_m_rreq), .o_rw_sel(rw_sel),
        .o_wr_beat(wr_beat), .o_rd_accept(rd_accept)
    );

    ring_tracker tracker_inst (
        .clk(clk), .reset(reset),
        .i_wr_beat(wr_beat), .i_rd_accept(rd_accept), .i_rd_bcnt(rd_bcnt),
        .o_used(used_cnt), .o_free(free_cnt), .o_full(ring_full), .o_empty(ring_empty)
    );

    burst_sizer sizer_inst (
        .clk(clk), .reset(reset),
        .i_wr_req(o_m_wreq), .i_rd_req(o_m_rreq), .i_rw_sel(rw_sel),
        .i_wr_beat(wr_beat), .i_rd_accept(rd_accept), .i_ififo_used(ififo_used),
        .i_used(used_cnt), .i_free(free_cnt), .i_out_pop(out_pop), .i_out_rdy(i_rdy_out),
        .o_wr_last(wr_last), .o_rd_bcnt(rd_bcnt), .o_m_addr(o_m_addr),
        .o_m_bcnt(o_m_bcnt), .o_rd_stall(rd_stall)
    );

endmodule : mm_stream_buffer

`default_nettype wire

//--- hw/burst_sizer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm_buf_cfg.svh"

module burst_sizer (
    input  wire                         clk,
    input  wire                         reset,

    input  wire                         i_wr_req,
    input  wire                         i_rd_req,
    input  wire                         i_rw_sel,
    input  wire                         i_wr_beat,
    input  wire                         i_rd_accept,

    input  wire mm_buf_pkg::ififo_cnt_t i_ififo_used,   // Input FIFO fill
    input  wire mm_buf_pkg::ring_cnt_t  i_used,         // Ring words held
    input  wire mm_buf_pkg::ring_cnt_t  i_free,         // Ring words free
    input  wire                         i_out_pop,      // Output handshake
    input  wire                         i_out_rdy,      // Output sink ready

    output logic                        o_wr_last,
    output mm_buf_pkg::bcnt_t           o_rd_bcnt,
    output mm_buf_pkg::addr_t           o_m_addr,
    output mm_buf_pkg::bcnt_t           o_m_bcnt,
    output logic                        o_rd_stall
);

    import mm_buf_pkg::*;

    bcnt_t      wr_bcnt;        // Write burst length, frozen while requesting
    bcnt_t      wr_cnt;         // Write beats left
    bcnt_t      wr_max;
    bcnt_t      wr_len;
    bcnt_t      rd_max;
    bcnt_t      rd_len;
    addr_t      wr_addr;
    addr_t      rd_addr;
    ofifo_cnt_t credit;         // Output FIFO words not yet promised
    ofifo_cnt_t credit_take;
    logic       stall_reg;

    //------------------------------------------------------------
    // Length limits
    assign wr_max = (i_ififo_used > MAXBURST) ? bcnt_t'(MAXBURST) : bcnt_t'(i_ififo_used);
    assign wr_len = (i_free > ring_cnt_t'(wr_max)) ? wr_max : bcnt_t'(i_free);
    assign rd_max = (credit > MAXBURST) ? bcnt_t'(MAXBURST) : bcnt_t'(credit);
    assign rd_len = (i_used > ring_cnt_t'(rd_max)) ? rd_max : bcnt_t'(i_used);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_bcnt   <= '0;
            wr_cnt    <= '0;
            o_rd_bcnt <= '0;
        end else begin
            if (!i_wr_req) begin                // Track limits until the burst starts
                wr_bcnt <= wr_len;
                wr_cnt  <= wr_len;
            end else if (i_wr_beat) begin
                wr_cnt  <= wr_cnt - 1'b1;
            end
            if (!i_rd_req)
                o_rd_bcnt <= rd_len;
        end
    end

    assign o_wr_last = (wr_cnt == bcnt_t'(1));

    //------------------------------------------------------------
    // Ring addresses, wrap by width
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (i_wr_beat && o_wr_last)
                wr_addr <= wr_addr + addr_t'(wr_bcnt);     // Whole burst done
            if (i_rd_accept)
                rd_addr <= rd_addr + addr_t'(o_rd_bcnt);
        end
    end

    //------------------------------------------------------------
    // Output credit and read stall
    assign credit_take = i_rd_accept ? ofifo_cnt_t'(o_rd_bcnt) : '0;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            credit    <= ofifo_cnt_t'(`MMB_ODEPTH);
            stall_reg <= 1'b0;
        end else begin
            credit <= credit - credit_take + ofifo_cnt_t'(i_out_pop);
            if (stall_reg)
                stall_reg <= ~i_out_rdy;            // Held until the sink moves
            else
                stall_reg <= i_rd_accept & ~i_out_rdy & (credit <= ofifo_cnt_t'(o_rd_bcnt));
        end
    end

    // No credit at all also blocks a read, so no zero-length burst goes out
    assign o_rd_stall = stall_reg | (credit == '0);

    assign o_m_addr = i_rw_sel ? wr_addr : rd_addr;
    assign o_m_bcnt = i_rw_sel ? wr_bcnt : o_rd_bcnt;

endmodule : burst_sizer

`default_nettype wire

//--- hw/ring_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module ring_tracker (
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     i_wr_beat,      // One word into the ring
    input  wire                     i_rd_accept,    // Read burst taken
    input  wire mm_buf_pkg::bcnt_t  i_rd_bcnt,      // Length of that burst

    output mm_buf_pkg::ring_cnt_t   o_used,
    output mm_buf_pkg::ring_cnt_t   o_free,
    output logic                    o_full,
    output logic                    o_empty
);

    import mm_buf_pkg::*;

    ring_cnt_t rd_len;                              // Burst length widened

    assign rd_len = ring_cnt_t'(i_rd_bcnt);

    //------------------------------------------------------------
    // Occupancy counters
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            o_used <= '0;
            o_free <= ring_cnt_t'(CAPACITY);        // Whole ring free
        end else if (i_wr_beat) begin
            o_used <= o_used + 1'b1;
            o_free <= o_free - 1'b1;
        end else if (i_rd_accept) begin
            o_used <= o_used - rd_len;
            o_free <= o_free + rd_len;
        end
    end

    //------------------------------------------------------------
    // Full flag
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            o_full <= 1'b0;
        else if (o_full)
            o_full <= ~i_rd_accept;                 // Any read frees space
        else
            o_full <= i_wr_beat & (o_used == ring_cnt_t'(CAPACITY - 1));
    end

    // Empty flag, set at reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            o_empty <= 1'b1;
        else if (o_empty)
            o_empty <= ~i_wr_beat;
        else
            o_empty <= i_rd_accept & (o_used <= rd_len);   // Read takes the rest
    end

endmodule : ring_tracker

`default_nettype wire

//--- hw/burst_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module burst_arbiter (
    input  wire     clk,
    input  wire     reset,

    input  wire     i_busy,         // Memory stall
    input  wire     i_wr_ready,     // Write burst possible
    input  wire     i_rd_ready,     // Read burst possible
    input  wire     i_wr_last,      // Current write beat ends the burst

    output logic    o_wr_req,
    output logic    o_rd_req,
    output logic    o_rw_sel,       // 1 selects write address and length
    output logic    o_wr_beat,
    output logic    o_rd_accept
);

    // Bit 0 read request, bit 1 write request, bit 2 write side selected
    typedef enum logic [2 : 0] {
        st_rd_idle = 3'b000,        // Last burst was a read, writes first
        st_rd_exec = 3'b001,
        st_wr_idle = 3'b100,        // Last burst was a write, reads first
        st_wr_exec = 3'b110
    } state_t;

    state_t state;
    state_t state_nxt;

    //------------------------------------------------------------
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_rd_idle:
                if (i_wr_ready)
                    state_nxt = st_wr_exec;
                else if (i_rd_ready)
                    state_nxt = st_rd_exec;
            st_rd_exec:
                if (!i_busy)                        // Accepted in one cycle
                    state_nxt = i_wr_ready ? st_wr_exec : st_rd_idle;
            st_wr_idle:
                if (i_rd_ready)
                    state_nxt = st_rd_exec;
                else if (i_wr_ready)
                    state_nxt = st_wr_exec;
            st_wr_exec:
                if (!i_busy && i_wr_last)           // Final beat
                    state_nxt = i_rd_ready ? st_rd_exec : st_wr_idle;
            default:
                state_nxt = st_rd_idle;             // Unused codes recover
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            state <= st_rd_idle;
        else
            state <= state_nxt;
    end

    // Strobes straight from the state code
    assign o_rd_req    = state[0];
    assign o_wr_req    = state[1];
    assign o_rw_sel    = state[2];
    assign o_wr_beat   = o_wr_req & ~i_busy;        // One word moved
    assign o_rd_accept = o_rd_req & ~i_busy;        // Whole read burst taken

endmodule : burst_arbiter

`default_nettype wire

//--- hw/stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type         T     = logic [7 : 0],   // Payload word
    parameter int unsigned DEPTH = 8                 // Words held
) (
    input  wire                                 clk,
    input  wire                                 reset,

    input  wire T                               i_data,
    input  wire                                 i_push,
    input  wire                                 i_pop,

    output T                                    o_data,     // Head word, show-ahead
    output logic                                o_empty,
    output logic                                o_full,
    output logic [$clog2(DEPTH + 1) - 1 : 0]    o_used
);

    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer bits
    localparam int unsigned CW = $clog2(DEPTH + 1);                // Count bits

    T                   mem [DEPTH];    // Register array
    logic [AW - 1 : 0]  wr_ptr;
    logic [AW - 1 : 0]  rd_ptr;
    logic [CW - 1 : 0]  count;
    logic               push_ok;        // Push not blocked by full
    logic               pop_ok;         // Pop not blocked by empty

    // Wrap at DEPTH, also for depths that are not a power of 2
    function automatic logic [AW - 1 : 0] next_ptr(input logic [AW - 1 : 0] ptr);
        if (ptr == AW'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign push_ok = i_push & ~o_full;
    assign pop_ok  = i_pop & ~o_empty;

    //------------------------------------------------------------
    // Storage
    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= i_data;
    end

    //------------------------------------------------------------
    // Pointers and fill count
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_ok)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    assign o_data  = mem[rd_ptr];               // Word visible the cycle after its push
    assign o_empty = (count == '0);
    assign o_full  = (count == CW'(DEPTH));
    assign o_used  = count;

endmodule : stream_fifo

`default_nettype wire

//--- hw/mm_buf_pkg.sv
`default_nettype none

`include "mm_buf_cfg.svh"

package mm_buf_pkg;

    // Words and addresses
    typedef logic [`MMB_DWIDTH - 1 : 0]                data_t;
    typedef logic [`MMB_AWIDTH - 1 : 0]                addr_t;
    typedef logic [`MMB_BWIDTH - 1 : 0]                bcnt_t;

    // Occupancy of the ring, one extra bit for the full count
    typedef logic [`MMB_AWIDTH : 0]                    ring_cnt_t;

    // FIFO used-word and credit counts
    typedef logic [$clog2(`MMB_IDEPTH + 1) - 1 : 0]    ififo_cnt_t;
    typedef logic [$clog2(`MMB_ODEPTH + 1) - 1 : 0]    ofifo_cnt_t;

    // Longest burst, top code of bcnt_t kept free
    localparam int unsigned MAXBURST = 2 ** (`MMB_BWIDTH - 1);

    // Ring size in words
    localparam int unsigned CAPACITY = 2 ** `MMB_AWIDTH;

endpackage : mm_buf_pkg

`default_nettype wire

//--- hw/mm_buf_cfg.svh
`ifndef MM_BUF_CFG_SVH
`define MM_BUF_CFG_SVH

// Stream and memory word width
`define MMB_DWIDTH  8

// Ring address width, 64 words
`define MMB_AWIDTH  6

// Burst length width, longest burst is 2**(width-1)
`define MMB_BWIDTH  4

//------------------------------------------------------------
// Stream side buffering
`define MMB_IDEPTH  8   // Input FIFO words
`define MMB_ODEPTH  8   // Output FIFO words

`endif
